// ==== common/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// byte address into the shared RAM
`define MEM_ADDR_WIDTH 32

// instructions and load/store data
`define MEM_WORD_WIDTH 32

// size of the byte-wide RAM behind the port
`define MEM_BYTES 4096

`endif

// ==== common/memPkg.sv ====
`include "mem_config.svh"

package memPkg;

    // byte address
    typedef logic [`MEM_ADDR_WIDTH-1:0] addrT;

    // full data word or instruction
    typedef logic [`MEM_WORD_WIDTH-1:0] wordT;

    // one RAM location
    typedef logic [7:0] byteT;

    // access length in bytes, only 1, 2 or 4 are legal
    typedef logic [2:0] lenT;

    // byte position inside an access
    typedef logic [1:0] offsetT;

    // instruction fetches are always a full word
    localparam lenT wordBytes = 3'd4;

    // FSM states, also the kind of access in flight
    typedef enum logic [1:0] {
        idle,
        fetch,
        load,
        store
    } accessKindT;

endpackage

// ==== common/portPkg.sv ====
package portPkg;

    // instruction fetch request, single-cycle strobe
    typedef struct packed {
        logic         strobe;
        memPkg::addrT addr;
    } fetchReqT;

    // fetch completion, inst valid while done is high
    typedef struct packed {
        logic         done;
        memPkg::wordT inst;
    } fetchRspT;

    // load/store request from the data side
    typedef struct packed {
        logic         strobe;
        logic         store;
        memPkg::lenT  len;
        memPkg::addrT addr;
        memPkg::wordT wdata;
    } dataReqT;

    // load data is zero-extended, don't care for stores
    typedef struct packed {
        logic         done;
        memPkg::wordT rdata;
    } dataRspT;

    // byte-wide RAM port, read data comes back one cycle later
    typedef struct packed {
        logic         enable;
        logic         write;
        memPkg::addrT addr;
        memPkg::byteT wdata;
    } ramReqT;

endpackage

// ==== hw/memCtrl/memCtrlFsm.sv ====
`timescale 1ns/100ps

module memCtrlFsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               ioFull,
    input  portPkg::fetchReqT  fetchReq,
    input  portPkg::dataReqT   dataReq,
    output memPkg::accessKindT kind,
    output memPkg::addrT       fetchAddr,
    output logic               start,
    output memPkg::offsetT     offset,
    output logic               ramEnable,
    output logic               ramWrite,
    output logic               capture,
    output logic               fetchDone,
    output logic               dataDone,
    output logic               busy
);

    memPkg::accessKindT state;
    memPkg::accessKindT launchKind;
    memPkg::lenT        lenQ;
    memPkg::lenT        count;
    memPkg::addrT       pendAddr;
    logic               pendValid;
    logic               holdFetch;
    logic               readPend;
    logic               lastByte;

    // pending fetch goes first, then data, then a new fetch
    always_comb begin
        launchKind = memPkg::idle;
        if (pendValid) begin
            launchKind = memPkg::fetch;
        end else if (dataReq.strobe) begin
            launchKind = dataReq.store ? memPkg::store : memPkg::load;
        end else if (fetchReq.strobe) begin
            launchKind = memPkg::fetch;
        end
    end

    assign start = (state == memPkg::idle) && !ioFull && (launchKind != memPkg::idle);
    assign holdFetch = start && !pendValid && dataReq.strobe && fetchReq.strobe;

    // kind of the access being launched while start is high
    assign kind = start ? launchKind : state;
    assign fetchAddr = pendValid ? pendAddr : fetchReq.addr;

    assign offset = count[1:0];
    assign busy = (state != memPkg::idle) || pendValid;

    // one RAM cycle per byte and none while frozen
    assign ramWrite = (state == memPkg::store);
    assign ramEnable = !ioFull && (state != memPkg::idle) && (count < lenQ);

    // byte read in the previous active cycle is on ramData now
    assign capture = readPend && !ioFull;
    assign lastByte = capture && (count == lenQ);

    assign fetchDone = lastByte && (state == memPkg::fetch);

    // store completes with its last write and loads one cycle after the last read
    assign dataDone = (lastByte && (state == memPkg::load)) ||
                      (ramEnable && ramWrite && (count == lenQ - 3'd1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::idle;
            lenQ <= '0;
            count <= '0;
            pendValid <= 1'b0;
            readPend <= 1'b0;
        end else if (!ioFull) begin
            readPend <= ramEnable && !ramWrite;
            if (start) begin
                state <= launchKind;
                count <= '0;
                if (launchKind == memPkg::fetch) begin
                    lenQ <= memPkg::wordBytes;
                end else begin
                    lenQ <= dataReq.len;
                end
                if (pendValid) begin
                    pendValid <= 1'b0;
                end else if (holdFetch) begin
                    pendValid <= 1'b1;
                end
            end else begin
                if (ramEnable) begin
                    count <= count + 3'd1;
                end
                if (fetchDone || dataDone) begin
                    state <= memPkg::idle;
                end
            end
        end
    end

    // fetch address parked behind a data access
    always_ff @(posedge clk) begin
        if (holdFetch) begin
            pendAddr <= fetchReq.addr;
        end
    end

    // clients watch busy instead of back-pressure
    noStrobeWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(fetchReq.strobe || dataReq.strobe));

    legalLength: assert property (@(posedge clk) disable iff (rst)
        dataReq.strobe |-> dataReq.len inside {3'd1, 3'd2, 3'd4});

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone));

endmodule

// ==== hw/memCtrl/addrSequencer.sv ====
`timescale 1ns/100ps

module addrSequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  memPkg::addrT   base,
    input  memPkg::offsetT offset,
    output memPkg::addrT   addr
);

    memPkg::addrT baseQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseQ <= '0;
        end else if (start) begin
            baseQ <= base;
        end
    end

    // bytes go out in ascending order from the request address
    assign addr = baseQ + memPkg::addrT'(offset);

endmodule

// ==== hw/memCtrl/loadAssembler.sv ====
`timescale 1ns/100ps

module loadAssembler (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           capture,
    input  memPkg::offsetT offset,
    input  memPkg::byteT   ramData,
    output memPkg::wordT   word
);

    memPkg::wordT   held;
    memPkg::offsetT lane;

    // byte counter has already moved past the byte being returned
    assign lane = offset - 2'd1;

    // last byte shows up in word the same cycle it arrives
    always_comb begin
        word = held;
        if (capture) begin
            word[{lane, 3'b000} +: 8] = ramData;
        end
    end

    // untouched lanes stay zero, which zero-extends short loads
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (start) begin
            held <= '0;
        end else begin
            held <= word;
        end
    end

    // RAM needs a cycle to answer the first read
    noEarlyCapture: assert property (@(posedge clk) disable iff (rst)
        start |=> !capture);

endmodule

// ==== hw/memCtrl/storeSerializer.sv ====
`timescale 1ns/100ps

module storeSerializer (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  memPkg::wordT   storeData,
    input  memPkg::offsetT offset,
    output memPkg::byteT   wrByte
);

    memPkg::wordT dataQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            dataQ <= '0;
        end else if (start) begin
            dataQ <= storeData;
        end
    end

    // little-endian, lane 0 goes first
    assign wrByte = dataQ[{offset, 3'b000} +: 8];

endmodule

// ==== hw/memCtrl/memCtrl.sv ====
`timescale 1ns/100ps

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  portPkg::fetchReqT fetchReq,
    output portPkg::fetchRspT fetchRsp,
    input  portPkg::dataReqT  dataReq,
    output portPkg::dataRspT  dataRsp,
    output portPkg::ramReqT   ram,
    input  memPkg::byteT      ramData,
    input  logic              ioFull,
    output logic              busy
);

    memPkg::accessKindT kind;
    memPkg::addrT       fetchAddr;
    memPkg::addrT       base;
    memPkg::addrT       addr;
    memPkg::offsetT     offset;
    memPkg::wordT       word;
    memPkg::byteT       wrByte;
    logic               start;
    logic               ramEnable;
    logic               ramWrite;
    logic               capture;
    logic               fetchDone;
    logic               dataDone;

    memCtrlFsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .ioFull    (ioFull),
        .fetchReq  (fetchReq),
        .dataReq   (dataReq),
        .kind      (kind),
        .fetchAddr (fetchAddr),
        .start     (start),
        .offset    (offset),
        .ramEnable (ramEnable),
        .ramWrite  (ramWrite),
        .capture   (capture),
        .fetchDone (fetchDone),
        .dataDone  (dataDone),
        .busy      (busy)
    );

    // fetchAddr is already the pending slot when one is waiting
    assign base = (kind == memPkg::fetch) ? fetchAddr : dataReq.addr;

    addrSequencer u_addr (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .base   (base),
        .offset (offset),
        .addr   (addr)
    );

    loadAssembler u_load (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .capture (capture),
        .offset  (offset),
        .ramData (ramData),
        .word    (word)
    );

    storeSerializer u_store (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .storeData (dataReq.wdata),
        .offset    (offset),
        .wrByte    (wrByte)
    );

    // one assembled word serves both clients
    assign fetchRsp = '{done: fetchDone, inst: word};
    assign dataRsp = '{done: dataDone, rdata: word};
    assign ram = '{enable: ramEnable, write: ramWrite, addr: addr, wdata: wrByte};

endmodule

// ==== test/ramModel.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module ramModel (
    input  logic            clk,
    input  portPkg::ramReqT ram,
    output memPkg::byteT    ramData,
    input  logic            fillEnable,
    input  memPkg::addrT    fillAddr,
    input  memPkg::byteT    fillByte
);

    localparam int addrBits = $clog2(`MEM_BYTES);

    memPkg::byteT mem [`MEM_BYTES];

    // preload port wins over the controller
    always_ff @(posedge clk) begin
        if (fillEnable) begin
            mem[fillAddr[addrBits-1:0]] <= fillByte;
        end else if (ram.enable && ram.write) begin
            mem[ram.addr[addrBits-1:0]] <= ram.wdata;
        end
    end

    // read byte holds until the next read, so it survives a freeze
    always_ff @(posedge clk) begin
        if (!fillEnable && ram.enable && !ram.write) begin
            ramData <= mem[ram.addr[addrBits-1:0]];
        end
    end

endmodule

// ==== test/tb_memCtrl.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module tb_memCtrl;

    localparam int accessBudget = 16;
    // preload, reset and twenty accesses
    localparam int cycleLimit = `MEM_BYTES + 8 + 20 * accessBudget + 64;

    logic              clk;
    logic              rst;
    logic              ioFull;
    logic              busy;
    portPkg::fetchReqT fetchReq;
    portPkg::fetchRspT fetchRsp;
    portPkg::dataReqT  dataReq;
    portPkg::dataRspT  dataRsp;
    portPkg::ramReqT   ram;
    memPkg::byteT      ramData;
    logic              fillEnable;
    memPkg::addrT      fillAddr;
    memPkg::byteT      fillByte;

    memPkg::byteT shadow [`MEM_BYTES];
    memPkg::addrT wrAddrs [$];
    memPkg::byteT wrBytes [$];
    integer       seed;
    int           errors = 0;
    int           cycles = 0;

    memCtrl u_dut (
        .clk      (clk),
        .rst      (rst),
        .fetchReq (fetchReq),
        .fetchRsp (fetchRsp),
        .dataReq  (dataReq),
        .dataRsp  (dataRsp),
        .ram      (ram),
        .ramData  (ramData),
        .ioFull   (ioFull),
        .busy     (busy)
    );

    ramModel u_ram (
        .clk        (clk),
        .ram        (ram),
        .ramData    (ramData),
        .fillEnable (fillEnable),
        .fillAddr   (fillAddr),
        .fillByte   (fillByte)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: run went past %0d clock cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // log of every byte written through the RAM port
    always @(negedge clk) begin
        if (ram.enable === 1'b1 && ram.write === 1'b1) begin
            wrAddrs.push_back(ram.addr);
            wrBytes.push_back(ram.wdata);
        end
    end

    task automatic checkWord(string name, memPkg::wordT got, memPkg::wordT exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkByte(string name, memPkg::byteT got, memPkg::byteT exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkAddr(string name, memPkg::addrT got, memPkg::addrT exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkCycles(string name, int got, int exp);
        if (got != exp) begin
            $display("ERR %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int ramIndex(memPkg::addrT a);
        return int'(a % `MEM_BYTES);
    endfunction

    // little-endian from the request address with upper lanes zero
    function automatic memPkg::wordT expectWord(memPkg::addrT a, int n);
        memPkg::wordT w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = shadow[ramIndex(a + memPkg::addrT'(i))];
        end
        return w;
    endfunction

    task automatic fillRam();
        memPkg::byteT b;
        for (int i = 0; i < `MEM_BYTES; i++) begin
            @(negedge clk);
            b = memPkg::byteT'($random(seed));
            fillEnable = 1'b1;
            fillAddr = memPkg::addrT'(i);
            fillByte = b;
            shadow[i] = b;
        end
        @(negedge clk);
        fillEnable = 1'b0;
    endtask

    // strobes for one cycle and returns in the middle of cycle 1
    task automatic issue(logic doFetch, memPkg::addrT fetchAddr, logic doData, logic isStore,
                         int len, memPkg::addrT dataAddr, memPkg::wordT wdata);
        @(negedge clk);
        fetchReq = '{strobe: doFetch, addr: fetchAddr};
        dataReq = '{strobe: doData, store: isStore, len: memPkg::lenT'(len),
                    addr: dataAddr, wdata: wdata};
        @(negedge clk);
        fetchReq.strobe = 1'b0;
        dataReq.strobe = 1'b0;
    endtask

    task automatic waitDone(logic fetchSide, int limit, inout int lat,
                            output memPkg::wordT word);
        logic seen;
        seen = 1'b0;
        while (!seen && lat <= limit) begin
            checkFlag("busy", busy, 1'b1);
            seen = fetchSide ? fetchRsp.done : dataRsp.done;
            if (!seen) begin
                @(negedge clk);
                lat++;
            end
        end
        word = fetchSide ? fetchRsp.inst : dataRsp.rdata;
        if (!seen) begin
            $display("no done strobe within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic finishAccess(logic fetchSide);
        @(negedge clk);
        checkFlag("done strobe width", fetchSide ? fetchRsp.done : dataRsp.done, 1'b0);
        checkFlag("busy", busy, 1'b0);
    endtask

    task automatic idleAfterReset();
        @(negedge clk);
        checkFlag("busy", busy, 1'b0);
        checkFlag("fetchRsp.done", fetchRsp.done, 1'b0);
        checkFlag("dataRsp.done", dataRsp.done, 1'b0);
        checkFlag("ram.enable", ram.enable, 1'b0);
    endtask

    task automatic singleFetch(memPkg::addrT a);
        memPkg::wordT w;
        int lat;
        issue(1'b1, a, 1'b0, 1'b0, 4, '0, '0);
        lat = 1;
        waitDone(1'b1, accessBudget, lat, w);
        checkWord("fetchRsp.inst", w, expectWord(a, 4));
        checkCycles("fetch latency", lat, 5);
        finishAccess(1'b1);
    endtask

    task automatic sizedLoad(memPkg::addrT a, int n);
        memPkg::wordT w;
        int lat;
        issue(1'b0, '0, 1'b1, 1'b0, n, a, '0);
        lat = 1;
        waitDone(1'b0, accessBudget, lat, w);
        checkWord("dataRsp.rdata", w, expectWord(a, n));
        checkCycles("load latency", lat, n + 1);
        finishAccess(1'b0);
    endtask

    task automatic sizedStore(memPkg::addrT a, int n, memPkg::wordT d);
        memPkg::wordT w;
        int lat;
        wrAddrs.delete();
        wrBytes.delete();
        issue(1'b0, '0, 1'b1, 1'b1, n, a, d);
        lat = 1;
        waitDone(1'b0, accessBudget, lat, w);
        checkCycles("store latency", lat, n);
        finishAccess(1'b0);
        checkCycles("store write count", wrAddrs.size(), n);
        for (int i = 0; i < n && i < wrAddrs.size(); i++) begin
            checkAddr("ram.addr", wrAddrs[i], a + memPkg::addrT'(i));
            checkByte("ram.wdata", wrBytes[i], d[8*i +: 8]);
        end
        for (int i = 0; i < n; i++) begin
            shadow[ramIndex(a + memPkg::addrT'(i))] = d[8*i +: 8];
        end
        // read back including the neighbours on both sides
        sizedLoad(a - 1, 1);
        sizedLoad(a, 4);
        sizedLoad(a + memPkg::addrT'(n), 1);
    endtask

    task automatic fetchBehindLoad(memPkg::addrT fetchAddr, memPkg::addrT dataAddr);
        memPkg::wordT w;
        int lat;
        issue(1'b1, fetchAddr, 1'b1, 1'b0, 2, dataAddr, '0);
        lat = 1;
        waitDone(1'b0, accessBudget, lat, w);
        checkFlag("fetchRsp.done", fetchRsp.done, 1'b0);
        checkWord("dataRsp.rdata", w, expectWord(dataAddr, 2));
        checkCycles("load latency", lat, 3);
        @(negedge clk);
        lat++;
        // parked fetch starts one cycle after the data done
        waitDone(1'b1, 2 * accessBudget, lat, w);
        checkWord("fetchRsp.inst", w, expectWord(fetchAddr, 4));
        checkCycles("pending fetch latency", lat, 9);
        finishAccess(1'b1);
    endtask

    task automatic frozenLoad(memPkg::addrT a, int k);
        memPkg::wordT w;
        int lat;
        issue(1'b0, '0, 1'b1, 1'b0, 4, a, '0);
        @(negedge clk);
        lat = 2;
        ioFull = 1'b1;
        for (int i = 0; i < k; i++) begin
            @(negedge clk);
            lat++;
            checkFlag("ram.enable", ram.enable, 1'b0);
            checkFlag("dataRsp.done", dataRsp.done, 1'b0);
        end
        ioFull = 1'b0;
        waitDone(1'b0, accessBudget, lat, w);
        checkWord("dataRsp.rdata", w, expectWord(a, 4));
        checkCycles("frozen load latency", lat, 5 + k);
        finishAccess(1'b0);
    endtask

    initial begin
        seed = 32'h1e83;
        rst = 1'b1;
        ioFull = 1'b0;
        fetchReq = '0;
        dataReq = '0;
        fillEnable = 1'b0;
        fillAddr = '0;
        fillByte = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idleAfterReset();
        fillRam();
        singleFetch(32'h0000_0100);
        singleFetch(32'h0000_07fd);
        sizedLoad(32'h0000_0123, 1);
        sizedLoad(32'h0000_0241, 2);
        sizedLoad(32'h0000_0362, 4);
        sizedStore(32'h0000_0200, 1, 32'h1234_565a);
        sizedStore(32'h0000_0301, 2, 32'h0bad_c0de);
        sizedStore(32'h0000_0402, 4, 32'hcafe_f00d);
        fetchBehindLoad(32'h0000_0680, 32'h0000_0511);
        frozenLoad(32'h0000_0555, 3);
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== memCtrl.f ====
+incdir+common
common/memPkg.sv
common/portPkg.sv
hw/memCtrl/memCtrlFsm.sv
hw/memCtrl/addrSequencer.sv
hw/memCtrl/loadAssembler.sv
hw/memCtrl/storeSerializer.sv
hw/memCtrl/memCtrl.sv
test/ramModel.sv
test/tb_memCtrl.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f memCtrl.f --top-module tb_memCtrl -o tb_memCtrl > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_memCtrl > sim.log 2>&1
grep -q "^Done: no errors$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }
